/* src/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define XLEN      32
`define ROB_DEPTH 8   // Entry 0 is never allocated
`define TAG_W     3
`define MEM_WORDS 64  // 32-bit words

`endif

/* src/op_pkg.sv */
package op_pkg;

    typedef enum logic [4:0] {
        OP_ADD  = 5'b00000,
        OP_AND  = 5'b00001,
        OP_OR   = 5'b00010,
        OP_SLL  = 5'b00011,
        OP_SRL  = 5'b00100,
        OP_SLT  = 5'b00101,
        OP_SLTU = 5'b00110,
        OP_SRA  = 5'b00111,
        OP_SUB  = 5'b01000,
        OP_XOR  = 5'b01001,
        OP_LUI  = 5'b01110,
        OP_LW   = 5'b10100,
        OP_SW   = 5'b11001,
        OP_NONE = 5'b11111
    } op_e;

    typedef enum logic [1:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE
    } op_class_e;

    function automatic op_class_e op_class(input op_e op);
        case (op)
            OP_LW:   return CLASS_LOAD;
            OP_SW:   return CLASS_STORE;
            default: return CLASS_ALU;
        endcase
    endfunction

endpackage

/* src/rob_pkg.sv */
`include "core_config.svh"

package rob_pkg;

    // Index into the reorder buffer, 0 means no producer
    typedef logic [`TAG_W-1:0] tag_t;

    typedef enum logic [1:0] {
        ST_BUSY,        // Still executing
        ST_STORE_READY, // Address and data known, waiting for head
        ST_DONE
    } rob_state_e;

endpackage

/* src/rob.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module rob import op_pkg::*, rob_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dispatch_valid,
    input  op_e               op,
    input  logic [4:0]        rd,
    input  logic              alu_free,
    input  logic              lsu_free,
    input  logic              cdb_valid,
    input  tag_t              cdb_tag,
    input  logic [`XLEN-1:0]  cdb_value,
    output logic              dispatch_ready,
    output logic              dispatch_fire,
    output logic              alu_issue,
    output logic              lsu_issue,
    output tag_t              alloc_tag,
    output logic              commit_valid,
    output logic [4:0]        commit_rd,
    output logic [`XLEN-1:0]  commit_value,
    output tag_t              commit_tag,
    output logic              store_commit
);

    localparam tag_t LAST = tag_t'(`ROB_DEPTH - 1);

    op_e              op_q    [`ROB_DEPTH];
    logic [4:0]       rd_q    [`ROB_DEPTH];
    logic [`XLEN-1:0] value_q [`ROB_DEPTH];
    rob_state_e       state_q [`ROB_DEPTH];

    tag_t       head;
    tag_t       tail;
    tag_t       count;  // Usable entries are 1..LAST
    op_class_e  cls;
    logic       full;
    logic       head_valid;

    function automatic tag_t next_tag(input tag_t t);
        return (t == LAST) ? tag_t'(1) : t + 1'b1;
    endfunction

    assign cls  = op_class(op);
    assign full = (count == LAST);

    assign dispatch_ready = !full && ((cls == CLASS_ALU) ? alu_free : lsu_free);
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    assign alu_issue      = dispatch_fire && (cls == CLASS_ALU);
    assign lsu_issue      = dispatch_fire && (cls != CLASS_ALU);
    assign alloc_tag      = tail;

    // Head state is stale when the buffer is empty
    assign head_valid   = (count != '0);
    assign store_commit = head_valid && (state_q[head] == ST_STORE_READY);
    assign commit_valid = head_valid &&
                          (state_q[head] == ST_DONE || state_q[head] == ST_STORE_READY);
    assign commit_rd    = rd_q[head];
    assign commit_value = store_commit ? '0 : value_q[head];
    assign commit_tag   = head;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= tag_t'(1);
            tail  <= tag_t'(1);
            count <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= ST_BUSY;
            end
        end else begin
            if (dispatch_fire) begin
                state_q[tail] <= ST_BUSY;
                tail          <= next_tag(tail);
            end
            if (cdb_valid) begin
                if (op_class(op_q[cdb_tag]) == CLASS_STORE) begin
                    state_q[cdb_tag] <= ST_STORE_READY;
                end else begin
                    state_q[cdb_tag] <= ST_DONE;
                end
            end
            if (commit_valid) begin
                head <= next_tag(head);
            end
            case ({dispatch_fire, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            op_q[tail] <= op;
            rd_q[tail] <= (cls == CLASS_STORE) ? 5'd0 : rd;  // Stores write no register
        end
        if (cdb_valid) begin
            value_q[cdb_tag] <= cdb_value;
        end
    end

endmodule

/* src/reg_rename.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module reg_rename import rob_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dispatch_fire,
    input  logic [4:0]        rd,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    input  logic [`XLEN-1:0]  imm,
    input  logic              has_imm,
    input  tag_t              alloc_tag,
    input  logic              cdb_valid,
    input  tag_t              cdb_tag,
    input  logic [`XLEN-1:0]  cdb_value,
    input  logic              commit_valid,
    input  logic [4:0]        commit_rd,
    input  logic [`XLEN-1:0]  commit_value,
    input  tag_t              commit_tag,
    output logic [`XLEN-1:0]  src1_value,
    output tag_t              src1_tag,
    output logic [`XLEN-1:0]  src2_value,
    output tag_t              src2_tag
);

    logic [`XLEN-1:0]     regs [32];
    tag_t                 prod [32];     // Producer tag per register
    logic [`XLEN-1:0]     res_buf [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] res_done;     // Broadcast but not yet committed

    // Returns {tag, value}, a nonzero tag means still pending
    function automatic logic [`TAG_W+`XLEN-1:0] lookup(input logic [4:0] r);
        tag_t t;
        t = prod[r];
        if (t == '0) begin
            return {t, regs[r]};
        end
        if (cdb_valid && cdb_tag == t) begin
            return {tag_t'(0), cdb_value};
        end
        if (res_done[t]) begin
            return {tag_t'(0), res_buf[t]};
        end
        return {t, {`XLEN{1'b0}}};
    endfunction

    always_comb begin
        {src1_tag, src1_value} = lookup(rs1);
        if (has_imm) begin
            src2_tag   = '0;
            src2_value = imm;
        end else begin
            {src2_tag, src2_value} = lookup(rs2);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
                prod[i] <= '0;
            end
            res_done <= '0;
        end else begin
            if (commit_valid && commit_rd != 5'd0) begin
                regs[commit_rd] <= commit_value;
                if (prod[commit_rd] == commit_tag) prod[commit_rd] <= '0;
            end
            // A rename in the same cycle overrides the clear above
            if (dispatch_fire && rd != 5'd0) prod[rd] <= alloc_tag;
            if (cdb_valid) res_done[cdb_tag] <= 1'b1;
            if (dispatch_fire) res_done[alloc_tag] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cdb_valid) res_buf[cdb_tag] <= cdb_value;
    end

endmodule

/* src/alu_station.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module alu_station import op_pkg::*, rob_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue,
    input  op_e               op,
    input  logic [`XLEN-1:0]  src1_value,
    input  tag_t              src1_tag,
    input  logic [`XLEN-1:0]  src2_value,
    input  tag_t              src2_tag,
    input  tag_t              alloc_tag,
    input  logic              cdb_valid,
    input  tag_t              cdb_tag,
    input  logic [`XLEN-1:0]  cdb_value,
    input  logic              grant,
    output logic              free,
    output logic              req,
    output tag_t              req_tag,
    output logic [`XLEN-1:0]  req_value
);

    logic             valid;
    op_e              op_q;
    tag_t             tag_q;
    tag_t             t1;
    tag_t             t2;
    logic [`XLEN-1:0] v1;
    logic [`XLEN-1:0] v2;
    logic             cap1;
    logic             cap2;

    assign cap1 = cdb_valid && t1 != '0 && cdb_tag == t1;
    assign cap2 = cdb_valid && t2 != '0 && cdb_tag == t2;

    assign free    = !valid;
    assign req     = valid && t1 == '0 && t2 == '0;  // Held until grant
    assign req_tag = tag_q;

    always_comb begin
        case (op_q)
            OP_ADD:  req_value = v1 + v2;
            OP_SUB:  req_value = v1 - v2;
            OP_AND:  req_value = v1 & v2;
            OP_OR:   req_value = v1 | v2;
            OP_XOR:  req_value = v1 ^ v2;
            OP_SLL:  req_value = v1 << v2[4:0];
            OP_SRL:  req_value = v1 >> v2[4:0];
            OP_SRA:  req_value = $signed(v1) >>> v2[4:0];
            OP_SLT:  req_value = {{(`XLEN-1){1'b0}}, $signed(v1) < $signed(v2)};
            OP_SLTU: req_value = {{(`XLEN-1){1'b0}}, v1 < v2};
            OP_LUI:  req_value = v2;  // Immediate comes in already shifted
            default: req_value = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            t1    <= '0;
            t2    <= '0;
        end else if (issue) begin
            valid <= 1'b1;
            t1    <= src1_tag;
            t2    <= src2_tag;
        end else begin
            if (cap1) t1 <= '0;
            if (cap2) t2 <= '0;
            if (grant) valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_q  <= op;
            tag_q <= alloc_tag;
            v1    <= src1_value;
            v2    <= src2_value;
        end else begin
            if (cap1) v1 <= cdb_value;
            if (cap2) v2 <= cdb_value;
        end
    end

endmodule

/* src/lsu_station.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module lsu_station import op_pkg::*, rob_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue,
    input  op_e               op,
    input  logic [`XLEN-1:0]  src1_value,
    input  tag_t              src1_tag,
    input  logic [`XLEN-1:0]  src2_value,  // Store data, so stores dispatch without has_imm
    input  tag_t              src2_tag,
    input  logic [`XLEN-1:0]  imm,
    input  tag_t              alloc_tag,
    input  logic              cdb_valid,
    input  tag_t              cdb_tag,
    input  logic [`XLEN-1:0]  cdb_value,
    input  logic              grant,
    input  logic              store_commit,
    output logic              free,
    output logic              req,
    output tag_t              req_tag,
    output logic [`XLEN-1:0]  req_value
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    logic [`XLEN-1:0] mem [`MEM_WORDS];

    logic             valid;
    logic             req_q;
    logic             hold;   // Store waiting at the head
    op_e              op_q;
    tag_t             tag_q;
    tag_t             t1;
    tag_t             t2;
    logic [`XLEN-1:0] v1;
    logic [`XLEN-1:0] v2;
    logic [`XLEN-1:0] imm_q;
    logic [`XLEN-1:0] res_q;
    logic [`XLEN-1:0] addr;
    logic [IDX_W-1:0] idx;
    logic             is_store;
    logic             cap1;
    logic             cap2;
    logic             start;

    assign is_store = (op_class(op_q) == CLASS_STORE);
    assign cap1     = cdb_valid && t1 != '0 && cdb_tag == t1;
    assign cap2     = cdb_valid && t2 != '0 && cdb_tag == t2;
    // Loads ignore the second operand
    assign start    = valid && !req_q && !hold && t1 == '0 && (t2 == '0 || !is_store);
    assign addr     = v1 + imm_q;
    assign idx      = addr[IDX_W+1:2];

    assign free      = !valid;
    assign req       = req_q;
    assign req_tag   = tag_q;
    assign req_value = res_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            req_q <= 1'b0;
            hold  <= 1'b0;
            t1    <= '0;
            t2    <= '0;
        end else if (issue) begin
            valid <= 1'b1;
            t1    <= src1_tag;
            t2    <= src2_tag;
        end else begin
            if (cap1) t1 <= '0;
            if (cap2) t2 <= '0;
            if (start) req_q <= 1'b1;
            if (grant) begin
                req_q <= 1'b0;
                if (is_store) hold <= 1'b1;
                else valid <= 1'b0;
            end
            if (hold && store_commit) begin
                hold  <= 1'b0;
                valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_q  <= op;
            tag_q <= alloc_tag;
            v1    <= src1_value;
            v2    <= src2_value;
            imm_q <= imm;
        end else begin
            if (cap1) v1 <= cdb_value;
            if (cap2) v2 <= cdb_value;
        end
        if (start) res_q <= is_store ? v2 : mem[idx];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (hold && store_commit) begin
            mem[idx] <= v2;
        end
    end

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module cdb_arbiter import rob_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alu_req,
    input  tag_t              alu_tag,
    input  logic [`XLEN-1:0]  alu_value,
    input  logic              lsu_req,
    input  tag_t              lsu_tag,
    input  logic [`XLEN-1:0]  lsu_value,
    output logic              alu_grant,
    output logic              lsu_grant,
    output logic              cdb_valid,
    output tag_t              cdb_tag,
    output logic [`XLEN-1:0]  cdb_value
);

    logic prio_lsu;  // Who wins the next tie

    assign alu_grant = alu_req && (!lsu_req || !prio_lsu);
    assign lsu_grant = lsu_req && (!alu_req || prio_lsu);
    assign cdb_valid = alu_req || lsu_req;
    assign cdb_tag   = alu_grant ? alu_tag : lsu_tag;
    assign cdb_value = alu_grant ? alu_value : lsu_value;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio_lsu <= 1'b0;
        end else if (alu_req && lsu_req) begin
            prio_lsu <= !prio_lsu;
        end
    end

endmodule

/* src/ooo_core.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module ooo_core import op_pkg::*, rob_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dispatch_valid,
    output logic              dispatch_ready,
    input  op_e               op,
    input  logic [4:0]        rd,
    input  logic [4:0]        rs1,
    input  logic [4:0]        rs2,
    input  logic [`XLEN-1:0]  imm,
    input  logic              has_imm,
    output logic              commit_valid,
    output logic [4:0]        commit_rd,
    output logic [`XLEN-1:0]  commit_value
);

    logic             dispatch_fire;
    logic             alu_issue;
    logic             lsu_issue;
    logic             alu_free;
    logic             lsu_free;
    tag_t             alloc_tag;
    tag_t             commit_tag;
    logic             store_commit;
    logic [`XLEN-1:0] src1_value;
    logic [`XLEN-1:0] src2_value;
    tag_t             src1_tag;
    tag_t             src2_tag;
    logic             alu_req;
    logic             lsu_req;
    logic             alu_grant;
    logic             lsu_grant;
    tag_t             alu_tag;
    tag_t             lsu_tag;
    logic [`XLEN-1:0] alu_value;
    logic [`XLEN-1:0] lsu_value;
    logic             cdb_valid;
    tag_t             cdb_tag;
    logic [`XLEN-1:0] cdb_value;

    rob u_rob (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .op             (op),
        .rd             (rd),
        .alu_free       (alu_free),
        .lsu_free       (lsu_free),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .dispatch_ready (dispatch_ready),
        .dispatch_fire  (dispatch_fire),
        .alu_issue      (alu_issue),
        .lsu_issue      (lsu_issue),
        .alloc_tag      (alloc_tag),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value),
        .commit_tag     (commit_tag),
        .store_commit   (store_commit)
    );

    reg_rename u_reg_rename (
        .clk           (clk),
        .arst_n        (arst_n),
        .dispatch_fire (dispatch_fire),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .imm           (imm),
        .has_imm       (has_imm),
        .alloc_tag     (alloc_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .commit_valid  (commit_valid),
        .commit_rd     (commit_rd),
        .commit_value  (commit_value),
        .commit_tag    (commit_tag),
        .src1_value    (src1_value),
        .src1_tag      (src1_tag),
        .src2_value    (src2_value),
        .src2_tag      (src2_tag)
    );

    alu_station u_alu (
        .clk        (clk),
        .arst_n     (arst_n),
        .issue      (alu_issue),
        .op         (op),
        .src1_value (src1_value),
        .src1_tag   (src1_tag),
        .src2_value (src2_value),
        .src2_tag   (src2_tag),
        .alloc_tag  (alloc_tag),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_value  (cdb_value),
        .grant      (alu_grant),
        .free       (alu_free),
        .req        (alu_req),
        .req_tag    (alu_tag),
        .req_value  (alu_value)
    );

    lsu_station u_lsu (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue        (lsu_issue),
        .op           (op),
        .src1_value   (src1_value),
        .src1_tag     (src1_tag),
        .src2_value   (src2_value),
        .src2_tag     (src2_tag),
        .imm          (imm),
        .alloc_tag    (alloc_tag),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_value    (cdb_value),
        .grant        (lsu_grant),
        .store_commit (store_commit),
        .free         (lsu_free),
        .req          (lsu_req),
        .req_tag      (lsu_tag),
        .req_value    (lsu_value)
    );

    cdb_arbiter u_cdb_arbiter (
        .clk       (clk),
        .arst_n    (arst_n),
        .alu_req   (alu_req),
        .alu_tag   (alu_tag),
        .alu_value (alu_value),
        .lsu_req   (lsu_req),
        .lsu_tag   (lsu_tag),
        .lsu_value (lsu_value),
        .alu_grant (alu_grant),
        .lsu_grant (lsu_grant),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

endmodule

/* tb/tb_ooo_core.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module tb_ooo_core import op_pkg::*; ();

    localparam int TIMEOUT = 200;  // Cycles per wait

    logic              clk;
    logic              arst_n;
    logic              dispatch_valid;
    logic              dispatch_ready;
    op_e               op;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [`XLEN-1:0]  imm;
    logic              has_imm;
    logic              commit_valid;
    logic [4:0]        commit_rd;
    logic [`XLEN-1:0]  commit_value;

    // Sequential reference state
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [`MEM_WORDS];
    logic [36:0] expected_q [$];  // {rd, value} in program order

    string test_name;
    int    seed;
    logic  saw_stall;

    op_e alu_ops [10] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                          OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
    op_e mix_ops [13] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL,
                          OP_SRA, OP_SLT, OP_SLTU, OP_LUI, OP_LW, OP_SW};

    ooo_core uut (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .op             (op),
        .rd             (rd),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .has_imm        (has_imm),
        .commit_valid   (commit_valid),
        .commit_rd      (commit_rd),
        .commit_value   (commit_value)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("error: %s %s expected 0x%08h actual 0x%08h",
                                test_name, what, exp, act));
        end
    endtask

    // RV32 integer semantics
    function automatic logic [31:0] alu_ref(input op_e o, input logic [31:0] a,
                                            input logic [31:0] b);
        case (o)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            OP_SRA:  return 32'($signed(a) >>> b[4:0]);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_LUI:  return b;
            default: return 32'd0;
        endcase
    endfunction

    // Updates the model, queues the expected commit, then hands the op to the DUT
    task automatic send(input op_e o, input logic [4:0] d, input logic [4:0] s1,
                        input logic [4:0] s2, input logic [31:0] im, input logic hi);
        logic [31:0] a;
        logic [31:0] res;
        int          idx;
        int          waited;
        a   = model_regs[s1];
        idx = int'(((a + im) >> 2) % `MEM_WORDS);
        if (o == OP_SW) begin
            model_mem[idx] = model_regs[s2];
            expected_q.push_back({5'd0, 32'd0});
        end else begin
            res = (o == OP_LW) ? model_mem[idx] : alu_ref(o, a, hi ? im : model_regs[s2]);
            if (d != 5'd0) model_regs[d] = res;
            expected_q.push_back({d, res});
        end
        op             = o;
        rd             = d;
        rs1            = s1;
        rs2            = s2;
        imm            = im;
        has_imm        = hi;
        dispatch_valid = 1'b1;
        waited         = 0;
        @(negedge clk);
        while (!dispatch_ready) begin
            saw_stall = 1'b1;
            waited++;
            if (waited > TIMEOUT) abort_run($sformatf("%s: dispatch never accepted", test_name));
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) abort_run($sformatf("%s: commits stopped coming", test_name));
        end
    endtask

    always @(negedge clk) begin : commit_monitor
        logic [36:0] exp_entry;
        if (arst_n === 1'b1 && commit_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                abort_run($sformatf("%s: commit seen with nothing outstanding", test_name));
            end else begin
                exp_entry = expected_q.pop_front();
                check_value("commit_rd", 32'(exp_entry[36:32]), 32'(commit_rd));
                check_value("commit_value", exp_entry[31:0], commit_value);
            end
        end
    end

    task automatic alu_op_sweep();
        test_name = "alu_ops";
        send(OP_LUI, 1, 0, 0, 32'h12345000, 1);
        send(OP_ADD, 1, 1, 0, 32'h00000678, 1);
        send(OP_LUI, 2, 0, 0, 32'h80000000, 1);
        send(OP_ADD, 3, 0, 0, 32'd5, 1);
        for (int i = 0; i < 10; i++) begin
            send(alu_ops[i], 5'(4 + i), 1, 2, 32'd0, 0);
        end
        for (int i = 0; i < 10; i++) begin
            send(alu_ops[i], 5'(14 + i), 2, 3, 32'd0, 0);
        end
        for (int i = 0; i < 10; i++) begin
            send(alu_ops[i], 31, 2, 0, 32'hfffff7f3, 1);  // Same rd each time
        end
        drain();
    endtask

    task automatic dependency_chain();
        test_name = "dep_chain";
        send(OP_ADD, 6, 0, 0, 32'd1, 1);
        for (int i = 0; i < 12; i++) begin
            send(OP_ADD, 6, 6, 6, 32'd0, 0);
        end
        send(OP_SUB, 7, 6, 1, 32'd0, 0);
        send(OP_XOR, 7, 7, 6, 32'd0, 0);
        send(OP_SRA, 8, 7, 3, 32'd0, 0);
        send(OP_SLT, 8, 8, 7, 32'd0, 0);
        send(OP_ADD, 20, 8, 0, 32'h10, 1);
        send(OP_SW, 0, 20, 6, 32'h4, 0);     // Base comes off the result bus
        send(OP_LW, 21, 20, 0, 32'h4, 1);
        send(OP_ADD, 22, 21, 20, 32'd0, 0);  // Waits for the load's tag
        drain();
    endtask

    task automatic store_then_load();
        test_name = "store_load";
        send(OP_ADD, 9, 0, 0, 32'h40, 1);
        send(OP_LUI, 10, 0, 0, 32'hcafe0000, 1);
        send(OP_OR, 10, 10, 0, 32'h00000bee, 1);
        send(OP_SW, 0, 9, 10, 32'h8, 0);
        send(OP_LW, 11, 9, 0, 32'h8, 1);
        send(OP_LW, 12, 9, 0, 32'h20, 1);     // Never written
        send(OP_ADD, 13, 11, 12, 32'd0, 0);
        send(OP_ADD, 14, 10, 10, 32'd0, 0);
        send(OP_SW, 0, 9, 14, 32'hc, 0);      // Data comes off the result bus
        send(OP_LW, 15, 9, 0, 32'hc, 1);
        drain();
    endtask

    task automatic burst_back_pressure();
        test_name = "back_pressure";
        saw_stall = 1'b0;
        for (int i = 0; i < 40; i++) begin
            if (i % 2 == 0) begin
                send(OP_LW, 5'(16 + i % 8), 9, 0, 32'(4 * (i % 4)), 1);
            end else begin
                send(OP_ADD, 5'(16 + i % 8), 5'(16 + (i + 7) % 8), 5'(16 + i % 8), 32'd0, 0);
            end
        end
        drain();
        check_value("dispatch_ready dropped", 32'd1, 32'(saw_stall));
    endtask

    task automatic random_op_mix();
        logic [31:0] r;
        logic [31:0] im;
        op_e         o;
        test_name = "random_mix";
        for (int i = 0; i < 200; i++) begin
            r  = $random(seed);
            im = $random(seed);
            o  = mix_ops[r[17:13] % 13];
            // Pool of x0 to x7 keeps ops dependent on each other
            if (o == OP_LUI) send(o, r[4:2], 0, 0, im & 32'hfffff000, 1);
            else if (o == OP_LW) send(o, r[4:2], r[7:5], 0, im, 1);
            else if (o == OP_SW) send(o, 0, r[7:5], r[10:8], im, 0);
            else send(o, r[4:2], r[7:5], r[10:8], im, r[20]);
        end
        send(OP_OR, 5, 0, 0, 32'd0, 0);  // x0 must still read as zero
        drain();
    endtask

    initial begin
        seed           = 49557;
        saw_stall      = 1'b0;
        test_name      = "reset";
        dispatch_valid = 1'b0;
        op             = OP_NONE;
        rd             = '0;
        rs1            = '0;
        rs2            = '0;
        imm            = '0;
        has_imm        = 1'b0;
        arst_n         = 1'b0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < `MEM_WORDS; i++) model_mem[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("commit_valid", 32'd0, 32'(commit_valid));
        check_value("dispatch_ready", 32'd1, 32'(dispatch_ready));
        @(posedge clk);
        #1;

        alu_op_sweep();
        dependency_chain();
        store_then_load();
        burst_back_pressure();
        random_op_mix();

        $display("All tests passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+src
src/op_pkg.sv
src/rob_pkg.sv
src/rob.sv
src/reg_rename.sv
src/alu_station.sv
src/lsu_station.sv
src/cdb_arbiter.sv
src/ooo_core.sv
tb/tb_ooo_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
